/* design/soc_params.svh */
// sizing and address map of the parallel I/O subsystem, included by the RTL that needs it
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// --------------------------------------------------------------------------
// port array
// --------------------------------------------------------------------------
`define NUM_PORTS	4	// identical ports in the array
`define PIO_WIDTH	8	// pins per port, 32 at most

// --------------------------------------------------------------------------
// address map
// --------------------------------------------------------------------------
`define PIO_BASE	32'hFFDC0600	// byte address of port 0
`define PIO_STRIDE	32	// bytes per port, eight word registers

// read value returned for an unmapped address
`define MISS_DATA	32'hCCEECCEE

`endif

/* design/soc_pkg.sv */
// shared enums for the I/O ports, imported by the decoder, interface and port modules
package soc_pkg;

	// register index, taken from adr[4:2]
	// indices 5..7 are unused: read zero, writes dropped
	typedef enum logic [2:0] {
		REG_DOUT  = 3'd0,	// output data
		REG_DIR   = 3'd1,	// 1 = pin driven
		REG_PIN   = 3'd2,	// synchronized pins, read only
		REG_IEN   = 3'd3,	// interrupt enables
		REG_IFLAG = 3'd4	// edge flags, write 1 to clear
	} pio_reg_e;

	// handshake phase of a slave
	typedef enum logic {
		IDLE = 1'b0,	// waiting for a strobe
		ACK  = 1'b1	// acked, waiting for the strobe to drop
	} bus_phase_e;

endpackage

/* design/pio_bus_if.sv */
// per-port slice of the Wishbone bus between decoder, one port and the return stage
`timescale 1ns/1ps

interface pio_bus_if import soc_pkg::*; ();

	// request side, driven by the decoder
	logic        sel;	// this port is addressed
	logic        stb;	// master strobe
	logic        we;	// write cycle
	logic [3:0]  be;	// byte lanes from sel_i
	pio_reg_e    idx;	// register index
	logic [31:0] wdata;	// write data

	// response side, driven by the port
	logic [31:0] rdata;	// read data, valid with ack
	logic        ack;	// one cycle pulse
	logic        irq;	// port interrupt

	modport dec (
		output sel, stb, we, be, idx, wdata
	);

	modport port (
		input  sel, stb, we, be, idx, wdata,
		output ack, rdata, irq
	);

	modport ret (
		input ack, rdata, irq
	);

endinterface

/* design/bus_decode.sv */
// address decoder that fans the master bus out to every port and flags unmapped accesses
`timescale 1ns/1ps
`include "soc_params.svh"

module bus_decode import soc_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  sel_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] dat_i,
	output logic        miss_o,	// ack from the nonexistent slave
	pio_bus_if.dec      port_o [`NUM_PORTS]
);

	localparam int          STRIDE_SH = $clog2(`PIO_STRIDE);
	localparam logic [31:0] SPAN      = `NUM_PORTS * `PIO_STRIDE;	// bytes covered by the array

	logic [31:0]           offset;	// byte offset from port 0
	logic                  in_range;
	logic [`NUM_PORTS-1:0] port_sel;
	logic                  miss_req;	// strobe to nowhere
	bus_phase_e            miss_phase;

	// addresses below the base wrap to a large offset and miss as well
	assign offset   = adr_i - `PIO_BASE;
	assign in_range = offset < SPAN;
	assign miss_req = cyc_i && stb_i && !in_range;

	// --------------------------------------------------------------------------
	// fan out to the ports
	// --------------------------------------------------------------------------
	for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_fan
		assign port_sel[i]    = cyc_i && in_range && ((offset >> STRIDE_SH) == 32'(i));
		assign port_o[i].sel   = port_sel[i];
		assign port_o[i].stb   = stb_i;
		assign port_o[i].we    = we_i;
		assign port_o[i].be    = sel_i;
		assign port_o[i].idx   = pio_reg_e'(adr_i[4:2]);	// word index inside the port
		assign port_o[i].wdata = dat_i;
	end

	// --------------------------------------------------------------------------
	// miss responder, same handshake as a port
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			miss_o     <= 1'b0;
			miss_phase <= IDLE;
		end else begin
			miss_o <= 1'b0;	// pulse only
			case (miss_phase)
				IDLE: begin
					if (miss_req) begin
						miss_o     <= 1'b1;
						miss_phase <= ACK;
					end
				end
				ACK: begin
					if (!miss_req)
						miss_phase <= IDLE;	// master dropped stb
				end
				default: miss_phase <= IDLE;
			endcase
		end
	end

	// at most one slave answers a strobe, a port or the miss responder
	a_one_slave: assert property (@(posedge clk) disable iff (rst)
		$onehot0({port_sel, miss_req}));

endmodule

/* design/pio_port.sv */
// one parallel I/O port with output data, direction, pin sync and edge interrupt for each slot of the port array
`timescale 1ns/1ps
`include "soc_params.svh"

module pio_port import soc_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	pio_bus_if.port               bus,
	input  logic [`PIO_WIDTH-1:0] pio_i,	// asynchronous raw pins
	output logic [`PIO_WIDTH-1:0] pio_o,
	output logic [`PIO_WIDTH-1:0] pio_oe_o	// 1 = drive the pin
);

	localparam int W = `PIO_WIDTH;

	bus_phase_e  phase;
	logic        req;	// new strobe for this port
	logic        wr_en;
	logic [W-1:0] wval;	// write data from the low lane
	logic [W-1:0] dout_r;
	logic [W-1:0] dir_r;
	logic [W-1:0] ien_r;
	logic [W-1:0] iflag_r;
	logic [W-1:0] sync1_r;	// first sync stage
	logic [W-1:0] sync2_r;	// stable pin value
	logic [W-1:0] pin_prev_r;	// for edge detect
	logic [W-1:0] rise;
	logic [W-1:0] flag_clr;
	logic [31:0]  rd_val;

	assign req   = bus.sel && bus.stb && (phase == IDLE);
	assign wr_en = req && bus.we && bus.be[0];	// registers live in byte lane 0
	assign wval  = bus.wdata[W-1:0];

	// --------------------------------------------------------------------------
	// handshake
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			phase   <= IDLE;
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= req;	// one cycle pulse
			if (req)
				phase <= ACK;
			else if (!(bus.sel && bus.stb))
				phase <= IDLE;	// ready again once the strobe is gone
		end
	end

	// --------------------------------------------------------------------------
	// pin synchronizer and edge detect
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			sync1_r    <= '0;
			sync2_r    <= '0;
			pin_prev_r <= '0;
		end else begin
			sync1_r    <= pio_i;
			sync2_r    <= sync1_r;
			pin_prev_r <= sync2_r;
		end
	end

	assign rise     = sync2_r & ~pin_prev_r;	// low to high
	assign flag_clr = (wr_en && bus.idx == REG_IFLAG) ? wval : '0;

	// --------------------------------------------------------------------------
	// registers
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			dout_r  <= '0;
			dir_r   <= '0;
			ien_r   <= '0;
			iflag_r <= '0;
		end else begin
			if (wr_en) begin
				case (bus.idx)
					REG_DOUT: dout_r <= wval;
					REG_DIR:  dir_r  <= wval;
					REG_IEN:  ien_r  <= wval;
					default:  ;	// pin and flag handled elsewhere
				endcase
			end
			iflag_r <= (iflag_r & ~flag_clr) | rise;	// a new edge wins over clear
		end
	end

	// read mux
	always_comb begin
		rd_val = '0;
		case (bus.idx)
			REG_DOUT:  rd_val[W-1:0] = dout_r;
			REG_DIR:   rd_val[W-1:0] = dir_r;
			REG_PIN:   rd_val[W-1:0] = sync2_r;
			REG_IEN:   rd_val[W-1:0] = ien_r;
			REG_IFLAG: rd_val[W-1:0] = iflag_r;
			default:   rd_val = '0;	// 5..7 read zero
		endcase
	end

	// captured with the ack and held until the next access
	always_ff @(posedge clk) begin
		if (req)
			bus.rdata <= rd_val;
	end

	assign bus.irq  = |(iflag_r & ien_r);
	assign pio_o    = dout_r & dir_r;	// inputs read back as 0
	assign pio_oe_o = dir_r;

	a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
		bus.ack |=> !bus.ack);

	// an ack answers a selected strobe that the master still holds
	a_ack_cause: assert property (@(posedge clk) disable iff (rst)
		bus.ack |-> bus.sel && bus.stb);

endmodule

/* design/bus_return.sv */
// return stage that merges port acks, read data and interrupts back to the bus master
`timescale 1ns/1ps
`include "soc_params.svh"

module bus_return (
	input  logic        clk,
	input  logic        rst,
	input  logic        cyc_i,
	input  logic        miss_i,	// unmapped access pulse
	pio_bus_if.ret      port_i [`NUM_PORTS],
	output logic        ack_o,
	output logic [31:0] dat_o,
	output logic        irq_o
);

	logic [`NUM_PORTS-1:0] acks;
	logic [`NUM_PORTS-1:0] irqs;
	logic [31:0]           rdata [`NUM_PORTS];
	logic [31:0]           rd_sel;	// data of the acking port

	// --------------------------------------------------------------------------
	// gather the port responses
	// --------------------------------------------------------------------------
	for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_gather
		assign acks[i]  = port_i[i].ack;
		assign irqs[i]  = port_i[i].irq;
		assign rdata[i] = port_i[i].rdata;
	end

	// and-or mux, acks are one-hot
	always_comb begin
		rd_sel = '0;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			if (acks[i])
				rd_sel |= rdata[i];
		end
	end

	// --------------------------------------------------------------------------
	// registered outputs
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			irq_o <= 1'b0;
		end else begin
			ack_o <= cyc_i && ((|acks) || miss_i);	// no ack once the cycle is aborted
			irq_o <= |irqs;
		end
	end

	always_ff @(posedge clk) begin
		if (|acks)
			dat_o <= rd_sel;
		else if (miss_i)
			dat_o <= `MISS_DATA;	// filler word, no bus error
	end

	// master holds cyc until it sees the ack
	a_ack_in_cyc: assert property (@(posedge clk) disable iff (rst)
		ack_o |-> cyc_i);

endmodule

/* design/pio_subsys.sv */
// top of the I/O subsystem: decoder, array of parallel ports and return stage on one bus
`timescale 1ns/1ps
`include "soc_params.svh"

module pio_subsys (
	input  logic                             clk,
	input  logic                             rst,
	// master bus
	input  logic                             cyc_i,
	input  logic                             stb_i,
	input  logic                             we_i,
	input  logic [3:0]                       sel_i,
	input  logic [31:0]                      adr_i,
	input  logic [31:0]                      dat_i,
	output logic                             ack_o,
	output logic [31:0]                      dat_o,
	output logic                             irq_o,
	// pins, port 0 in the low bits
	input  logic [`NUM_PORTS*`PIO_WIDTH-1:0] pio_i,
	output logic [`NUM_PORTS*`PIO_WIDTH-1:0] pio_o,
	output logic [`NUM_PORTS*`PIO_WIDTH-1:0] pio_oe_o
);

	localparam int W = `PIO_WIDTH;

	logic miss;	// decoder to return stage

	pio_bus_if pbus [`NUM_PORTS] ();

	bus_decode i_bus_decode (
		.clk    (clk),
		.rst    (rst),
		.cyc_i  (cyc_i),
		.stb_i  (stb_i),
		.we_i   (we_i),
		.sel_i  (sel_i),
		.adr_i  (adr_i),
		.dat_i  (dat_i),
		.miss_o (miss),
		.port_o (pbus)
	);

	// --------------------------------------------------------------------------
	// port array
	// --------------------------------------------------------------------------
	for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_port
		pio_port i_pio_port (
			.clk      (clk),
			.rst      (rst),
			.bus      (pbus[g]),
			.pio_i    (pio_i[g*W +: W]),
			.pio_o    (pio_o[g*W +: W]),
			.pio_oe_o (pio_oe_o[g*W +: W])
		);
	end

	bus_return i_bus_return (
		.clk    (clk),
		.rst    (rst),
		.cyc_i  (cyc_i),
		.miss_i (miss),
		.port_i (pbus),
		.ack_o  (ack_o),
		.dat_o  (dat_o),
		.irq_o  (irq_o)
	);

endmodule

/* sim/tb_vectors.svh */
// stimulus table for the I/O subsystem testbench, included inside the testbench module
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// operations of a table row
localparam logic [2:0] OP_WR    = 3'd0;	// register write
localparam logic [2:0] OP_RD    = 3'd1;	// register read and compare
localparam logic [2:0] OP_RDALL = 3'd2;	// read all eight registers
localparam logic [2:0] OP_PIN   = 3'd3;	// drive the port pins, let them settle
localparam logic [2:0] OP_OUTS  = 3'd4;	// compare pio_o, pio_oe_o, irq_o
localparam logic [2:0] OP_MISS  = 3'd5;	// read at an unmapped address

typedef struct packed {
	logic [2:0]  op;
	logic [2:0]  idx;	// register index
	logic        rnd;	// take data from the LCG
	logic [3:0]  be;	// byte lanes, sel_i
	logic [31:0] data;	// write data, pin value or miss address
	logic        lit;	// 1: compare with exp, 0: with the register model
	logic [31:0] exp;
} vec_t;

// every row runs once per port
// columns: op, reg, rnd, byte enables, data, literal check, expected
localparam int NUM_VECS = 26;
localparam vec_t VECS [NUM_VECS] = '{
	'{OP_WR,    REG_DIR,   1'b1, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_WR,    REG_DOUT,  1'b1, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_RD,    REG_DOUT,  1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_RD,    REG_DIR,   1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_OUTS,  REG_DOUT,  1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_WR,    REG_DOUT,  1'b1, 4'hE, 32'h0,         1'b0, 32'h0},	// lane 0 off
	'{OP_RD,    REG_DOUT,  1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_PIN,   REG_PIN,   1'b1, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_RD,    REG_PIN,   1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_RD,    REG_IFLAG, 1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_WR,    REG_IFLAG, 1'b0, 4'hF, 32'hFF,        1'b0, 32'h0},	// clear all
	'{OP_PIN,   REG_PIN,   1'b0, 4'hF, 32'h00,        1'b0, 32'h0},
	'{OP_WR,    REG_IEN,   1'b0, 4'hF, 32'h81,        1'b0, 32'h0},
	'{OP_OUTS,  REG_DOUT,  1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_PIN,   REG_PIN,   1'b0, 4'hF, 32'h81,        1'b0, 32'h0},	// two rising edges
	'{OP_RD,    REG_IFLAG, 1'b0, 4'hF, 32'h0,         1'b1, 32'h81},
	'{OP_OUTS,  REG_DOUT,  1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_WR,    REG_IFLAG, 1'b0, 4'hF, 32'h01,        1'b0, 32'h0},
	'{OP_RD,    REG_IFLAG, 1'b0, 4'hF, 32'h0,         1'b1, 32'h80},
	'{OP_WR,    REG_IFLAG, 1'b0, 4'hF, 32'h80,        1'b0, 32'h0},
	'{OP_OUTS,  REG_DOUT,  1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_WR,    3'd6,      1'b1, 4'hF, 32'h0,         1'b0, 32'h0},	// unused index
	'{OP_RD,    3'd6,      1'b0, 4'hF, 32'h0,         1'b1, 32'h0},
	'{OP_RDALL, REG_DOUT,  1'b0, 4'hF, 32'h0,         1'b0, 32'h0},
	'{OP_MISS,  REG_DOUT,  1'b0, 4'hF, 32'hFFDC0680,  1'b1, `MISS_DATA},	// past the array
	'{OP_MISS,  REG_DOUT,  1'b0, 4'hF, 32'hFFDC05FC,  1'b1, `MISS_DATA}	// below the base
};

`endif

/* sim/tb_pio_subsys.sv */
// testbench for the I/O subsystem: plays the bus master and checks against a register model
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_pio_subsys import soc_pkg::*; ();

	localparam int N           = `NUM_PORTS;
	localparam int W           = `PIO_WIDTH;
	localparam int ACK_EDGES   = 3;	// negedges from request drive to ack_o
	localparam int ACK_TIMEOUT = 20;

	`include "tb_vectors.svh"

	logic          clk;
	logic          rst;
	logic          cyc_i;
	logic          stb_i;
	logic          we_i;
	logic [3:0]    sel_i;
	logic [31:0]   adr_i;
	logic [31:0]   dat_i;
	logic          ack_o;
	logic [31:0]   dat_o;
	logic          irq_o;
	logic [N*W-1:0] pio_i;
	logic [N*W-1:0] pio_o;
	logic [N*W-1:0] pio_oe_o;

	// register model, one entry per port
	logic [W-1:0] m_dout  [N];
	logic [W-1:0] m_dir   [N];
	logic [W-1:0] m_ien   [N];
	logic [W-1:0] m_iflag [N];
	logic [W-1:0] m_pin   [N];
	logic [31:0]  lcg_state;

	pio_subsys i_pio_subsys (
		.clk      (clk),
		.rst      (rst),
		.cyc_i    (cyc_i),
		.stb_i    (stb_i),
		.we_i     (we_i),
		.sel_i    (sel_i),
		.adr_i    (adr_i),
		.dat_i    (dat_i),
		.ack_o    (ack_o),
		.dat_o    (dat_o),
		.irq_o    (irq_o),
		.pio_i    (pio_i),
		.pio_o    (pio_o),
		.pio_oe_o (pio_oe_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// --------------------------------------------------------------------------
	// error reporting and random numbers
	// --------------------------------------------------------------------------
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else
			stop_on_error($sformatf("[FAIL] time %0t: %s expected %08h, got %08h",
				$time, name, exp, act));
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {lcg_state[15:0], lcg_state[31:16]};	// high bits land in the low byte
	endfunction

	// --------------------------------------------------------------------------
	// register model
	// --------------------------------------------------------------------------
	function automatic logic [31:0] reg_addr(input int p, input logic [2:0] idx);
		return `PIO_BASE + 32'(p * `PIO_STRIDE) + 32'({idx, 2'b00});
	endfunction

	function automatic logic [31:0] model_read(input int p, input logic [2:0] idx);
		case (idx)
			REG_DOUT:  return 32'(m_dout[p]);
			REG_DIR:   return 32'(m_dir[p]);
			REG_PIN:   return 32'(m_pin[p]);
			REG_IEN:   return 32'(m_ien[p]);
			REG_IFLAG: return 32'(m_iflag[p]);
			default:   return 32'h0;	// 5..7 are empty
		endcase
	endfunction

	function automatic void model_write(input int p, input logic [2:0] idx,
			input logic [3:0] be, input logic [31:0] d);
		if (be[0]) begin	// registers sit in lane 0 only
			case (idx)
				REG_DOUT:  m_dout[p] = d[W-1:0];
				REG_DIR:   m_dir[p]  = d[W-1:0];
				REG_IEN:   m_ien[p]  = d[W-1:0];
				REG_IFLAG: m_iflag[p] = m_iflag[p] & ~d[W-1:0];	// write 1 to clear
				default:   ;
			endcase
		end
	endfunction

	function automatic logic irq_model();
		logic any;
		any = 1'b0;
		for (int q = 0; q < N; q++)
			any = any | (|(m_iflag[q] & m_ien[q]));
		return any;
	endfunction

	// --------------------------------------------------------------------------
	// bus master and pins
	// --------------------------------------------------------------------------
	task automatic bus_xfer(input logic we, input logic [31:0] adr, input logic [3:0] be,
			input logic [31:0] wd, output logic [31:0] rd);
		int   n;
		logic got;
		n   = 0;
		got = 1'b0;
		@(posedge clk);
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i  <= we;
		sel_i <= be;
		adr_i <= adr;
		dat_i <= wd;
		while (!got && n < ACK_TIMEOUT) begin
			@(negedge clk);	// outputs stable here
			n++;
			got = ack_o;
		end
		assert (got) else
			stop_on_error($sformatf("no ack_o within %0d cycles for address %08h",
				ACK_TIMEOUT, adr));
		check_val("ack_o latency", 32'(ACK_EDGES), 32'(n));
		rd = dat_o;
		@(posedge clk);
		cyc_i <= 1'b0;	// end of cycle
		stb_i <= 1'b0;
		we_i  <= 1'b0;
	endtask

	task automatic drive_pins(input int p, input logic [W-1:0] val);
		@(posedge clk);
		pio_i[p*W +: W] <= val;
		repeat (4) @(posedge clk);	// two sync flops, flag, then irq_o
		m_iflag[p] = m_iflag[p] | (val & ~m_pin[p]);	// rising edges only
		m_pin[p]   = val;
	endtask

	task automatic check_outputs(input int p);
		@(negedge clk);
		check_val($sformatf("pio_o port %0d", p), 32'(m_dout[p] & m_dir[p]),
			32'(pio_o[p*W +: W]));
		check_val($sformatf("pio_oe_o port %0d", p), 32'(m_dir[p]), 32'(pio_oe_o[p*W +: W]));
		check_val("irq_o", 32'(irq_model()), 32'(irq_o));
	endtask

	task automatic apply_vec(input int p, input vec_t v);
		logic [31:0] d;
		logic [31:0] rd;
		d = v.rnd ? next_random() : v.data;
		case (v.op)
			OP_WR: begin
				bus_xfer(1'b1, reg_addr(p, v.idx), v.be, d, rd);
				model_write(p, v.idx, v.be, d);
			end
			OP_RD: begin
				bus_xfer(1'b0, reg_addr(p, v.idx), 4'hF, 32'h0, rd);
				check_val($sformatf("dat_o port %0d reg %0d", p, v.idx),
					v.lit ? v.exp : model_read(p, v.idx), rd);
			end
			OP_RDALL: begin
				for (int k = 0; k < 8; k++) begin
					bus_xfer(1'b0, reg_addr(p, 3'(k)), 4'hF, 32'h0, rd);
					check_val($sformatf("dat_o port %0d reg %0d", p, k),
						model_read(p, 3'(k)), rd);
				end
			end
			OP_PIN:  drive_pins(p, d[W-1:0]);
			OP_OUTS: check_outputs(p);
			OP_MISS: begin
				bus_xfer(1'b0, v.data, 4'hF, 32'h0, rd);
				check_val($sformatf("dat_o miss at %08h", v.data), v.exp, rd);
			end
			default: stop_on_error("unknown operation in the stimulus table");
		endcase
	endtask

	// --------------------------------------------------------------------------
	// main sequence
	// --------------------------------------------------------------------------
	initial begin
		logic [31:0] rd;
		rst       = 1'b1;
		cyc_i     = 1'b0;
		stb_i     = 1'b0;
		we_i      = 1'b0;
		sel_i     = 4'h0;
		adr_i     = 32'h0;
		dat_i     = 32'h0;
		pio_i     = '0;
		lcg_state = 32'hee37;
		for (int p = 0; p < N; p++) begin
			m_dout[p]  = '0;
			m_dir[p]   = '0;
			m_ien[p]   = '0;
			m_iflag[p] = '0;
			m_pin[p]   = '0;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// every register and output starts at zero
		for (int p = 0; p < N; p++) begin
			for (int k = 0; k < 8; k++) begin
				bus_xfer(1'b0, reg_addr(p, 3'(k)), 4'hF, 32'h0, rd);
				check_val($sformatf("dat_o after reset port %0d reg %0d", p, k), 32'h0, rd);
			end
			check_outputs(p);
		end

		for (int p = 0; p < N; p++)
			for (int i = 0; i < NUM_VECS; i++)
				apply_vec(p, VECS[i]);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* build.f */
+incdir+design
+incdir+sim
design/soc_pkg.sv
design/pio_bus_if.sv
design/bus_decode.sv
design/pio_port.sv
design/bus_return.sv
design/pio_subsys.sv
sim/tb_pio_subsys.sv

/* Makefile */
# Verilator build and run of the parallel I/O subsystem testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_pio_subsys
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = SIMULATION PASSED

SOURCES   = $(wildcard design/*.sv design/*.svh sim/*.sv sim/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
